// File: verilog.f
logic/cpu_pkg.sv
logic/op_decoder.sv
logic/branch_decoder.sv
logic/decode_output.sv
logic/decode_stage.sv
tests/tb_clock_gen.sv
tests/decode_stage_tb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - logic/cpu_pkg.sv
  - logic/op_decoder.sv
  - logic/branch_decoder.sv
  - logic/decode_output.sv
  - logic/decode_stage.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/decode_stage_tb.sv

// File: tests/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
	import cpu_pkg::*;

	localparam int STALL_LIMIT = 1000;

	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		op_t       op;
		fu_t       fu;
		word_t     imm;
		cf_t       cf;
		logic      is_cf;
		word_t     target;
	} dec_t;

	logic      clk;
	logic      arst_n;
	logic      in_valid;
	logic      in_ready;
	word_t     instr;
	word_t     pc;
	logic      out_valid;
	logic      out_ready;
	reg_addr_t out_rs1;
	reg_addr_t out_rs2;
	reg_addr_t out_rd;
	op_t       out_op;
	fu_t       out_fu;
	word_t     out_imm;
	cf_t       out_cf;
	logic      out_is_controlflow;
	word_t     out_target;

	word_t       q_instr[$];
	word_t       q_pc[$];
	int          q_cycle[$];
	int          n_checks;
	int          n_errors;
	int          n_received;
	int          tests_ok;
	int          tests_bad;
	int          cycle;
	int          in_stalls;
	logic        lat_check;
	logic        rnd_ready;
	logic        held;
	logic [31:0] held_ctrl;
	logic [31:0] held_imm;
	logic [31:0] held_target;
	integer      seed;
	integer      ready_seed;
	event        stalled;
	string       stall_reason;

	tb_clock_gen clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	decode_stage dut0 (
		.clk                (clk),
		.arst_n             (arst_n),
		.in_valid           (in_valid),
		.in_ready           (in_ready),
		.instr              (instr),
		.pc                 (pc),
		.out_valid          (out_valid),
		.out_ready          (out_ready),
		.out_rs1            (out_rs1),
		.out_rs2            (out_rs2),
		.out_rd             (out_rd),
		.out_op             (out_op),
		.out_fu             (out_fu),
		.out_imm            (out_imm),
		.out_cf             (out_cf),
		.out_is_controlflow (out_is_controlflow),
		.out_target         (out_target)
	);

	function automatic dec_t decode_ref(input word_t w, input word_t p);
		dec_t       d;
		logic [5:0] opc;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rdf;
		logic       has_imm;
		logic       sext;
		logic       br;
		logic       ji;
		logic       jr;
		logic       call;
		logic       ret;
		word_t      npc;

		opc     = w[31:26];
		rs      = w[25:21];
		rt      = w[20:16];
		rdf     = w[15:11];
		fn      = w[5:0];
		d       = '0;
		d.op    = OP_INVALID;
		d.fu    = FU_INVALID;
		has_imm = 1'b0;
		sext    = 1'b1;

		case (opc)
			6'h00: begin
				d.rs1 = rs;
				d.rs2 = rt;
				d.rd  = rdf;
				d.fu  = (fn == 6'h08 || fn == 6'h09) ? FU_BRANCH : FU_ALU;
				case (fn)
					6'h00, 6'h0f: d.op = OP_SLL;   // sync decodes as nop
					6'h02: d.op = OP_SRL;
					6'h03: d.op = OP_SRA;
					6'h04: d.op = OP_SLLV;
					6'h06: d.op = OP_SRLV;
					6'h07: d.op = OP_SRAV;
					6'h08, 6'h09: d.op = OP_JALR;
					6'h0a: d.op = OP_MOVZ;
					6'h0b: d.op = OP_MOVN;
					6'h0c: d.op = OP_SYSCALL;
					6'h0d: d.op = OP_BREAK;
					6'h10: d.op = OP_MFHI;
					6'h11: d.op = OP_MTHI;
					6'h12: d.op = OP_MFLO;
					6'h13: d.op = OP_MTLO;
					6'h18: d.op = OP_MULT;
					6'h19: d.op = OP_MULTU;
					6'h1a: d.op = OP_DIV;
					6'h1b: d.op = OP_DIVU;
					6'h20: d.op = OP_ADD;
					6'h21: d.op = OP_ADDU;
					6'h22: d.op = OP_SUB;
					6'h23: d.op = OP_SUBU;
					6'h24: d.op = OP_AND;
					6'h25: d.op = OP_OR;
					6'h26: d.op = OP_XOR;
					6'h27: d.op = OP_NOR;
					6'h2a: d.op = OP_SLT;
					6'h2b: d.op = OP_SLTU;
					6'h30: d.op = OP_TGE;
					6'h31: d.op = OP_TGEU;
					6'h32: d.op = OP_TLT;
					6'h33: d.op = OP_TLTU;
					6'h34: d.op = OP_TEQ;
					6'h36: d.op = OP_TNE;
					default: d.op = OP_INVALID;
				endcase
			end
			6'h1c: begin   // special2 carries no unit
				d.rs1 = rs;
				d.rs2 = rt;
				d.rd  = rdf;
				case (fn)
					6'h00: d.op = OP_MADD;
					6'h01: d.op = OP_MADDU;
					6'h02: d.op = OP_MUL;
					6'h04: d.op = OP_MSUB;
					6'h05: d.op = OP_MSUBU;
					6'h20: d.op = OP_CLZ;
					6'h21: d.op = OP_CLO;
					default: d.op = OP_INVALID;
				endcase
			end
			6'h01: begin   // regimm traps carry no unit
				d.rs1   = rs;
				d.rd    = (rt == 5'h10 || rt == 5'h11) ? 5'd31 : 5'd0;
				d.fu    = (rt == 5'h00 || rt == 5'h01 || rt == 5'h10 || rt == 5'h11) ?
					FU_BRANCH : FU_INVALID;
				has_imm = 1'b1;
				case (rt)
					5'h00: d.op = OP_BLTZ;
					5'h01: d.op = OP_BGEZ;
					5'h08: d.op = OP_TGE;
					5'h09: d.op = OP_TGEU;
					5'h0a: d.op = OP_TLT;
					5'h0b: d.op = OP_TLTU;
					5'h0c: d.op = OP_TEQ;
					5'h0e: d.op = OP_TNE;
					5'h10: d.op = OP_BLTZAL;
					5'h11: d.op = OP_BGEZAL;
					default: d.op = OP_INVALID;
				endcase
			end
			6'h02, 6'h03: begin
				d.rd = (opc == 6'h03) ? 5'd31 : 5'd0;
				d.fu = FU_BRANCH;
				d.op = OP_JAL;
			end
			6'h04, 6'h05, 6'h06, 6'h07: begin
				d.rs1 = rs;
				d.rs2 = rt;
				d.fu  = FU_BRANCH;
				case (opc)
					6'h04: d.op = OP_BEQ;
					6'h05: d.op = OP_BNE;
					6'h06: d.op = OP_BLEZ;
					default: d.op = OP_BGTZ;
				endcase
			end
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				d.rs1   = rs;
				d.rd    = rt;
				d.fu    = FU_ALU;
				has_imm = 1'b1;
				sext    = (opc < 6'h0c);   // andi/ori/xori/lui zero-extend
				case (opc)
					6'h08: d.op = OP_ADD;
					6'h09: d.op = OP_ADDU;
					6'h0a: d.op = OP_SLT;
					6'h0b: d.op = OP_SLTU;
					6'h0c: d.op = OP_AND;
					6'h0d: d.op = OP_OR;
					6'h0e: d.op = OP_XOR;
					default: d.op = OP_LUI;
				endcase
			end
			6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27: begin
				d.rs1 = rs;
				d.rd  = rt;
				d.fu  = FU_LOAD;
				if (opc == 6'h22 || opc == 6'h26)
					d.rs2 = rt;   // lwl/lwr read the old rt
				case (opc)
					6'h20: d.op = OP_LB;
					6'h21: d.op = OP_LH;
					6'h22: d.op = OP_LWL;
					6'h23: d.op = OP_LW;
					6'h24: d.op = OP_LBU;
					6'h25: d.op = OP_LHU;
					6'h26: d.op = OP_LWR;
					default: d.op = OP_INVALID;
				endcase
			end
			6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2c, 6'h2d, 6'h2e, 6'h2f: begin
				d.rs1 = rs;
				d.rs2 = rt;
				d.fu  = FU_STORE;
				case (opc)
					6'h28: d.op = OP_SB;
					6'h29: d.op = OP_SH;
					6'h2a: d.op = OP_SWL;
					6'h2b: d.op = OP_SW;
					6'h2e: d.op = OP_SWR;
					6'h2f: d.op = OP_CACHE;
					default: d.op = OP_INVALID;
				endcase
			end
			6'h30: begin
				d.rs1 = rs;
				d.rd  = rt;
				d.fu  = FU_LOAD;
				d.op  = OP_LL;
			end
			6'h38: begin
				d.rs1 = rs;
				d.rs2 = rt;
				d.rd  = rt;
				d.fu  = FU_STORE;
				d.op  = OP_SC;
			end
			6'h10: begin
				d.fu = FU_CP0;
				if (rs == 5'h00) begin
					d.op = OP_MFC0;
					d.rd = rt;
				end else if (rs == 5'h04) begin
					d.op  = OP_MTC0;
					d.rs1 = rt;
				end else if (rs == 5'h10) begin
					case (fn)
						6'h01: d.op = OP_TLBR;
						6'h02: d.op = OP_TLBWI;
						6'h06: d.op = OP_TLBWR;
						6'h08: d.op = OP_TLBP;
						6'h18: d.op = OP_ERET;
						default: d.op = OP_INVALID;
					endcase
				end
			end
			default: d.op = OP_INVALID;
		endcase

		br   = (opc >= 6'h04 && opc <= 6'h07) ||
			(opc == 6'h01 && (rt == 5'h00 || rt == 5'h01 || rt == 5'h10 || rt == 5'h11));
		ji   = (opc == 6'h02 || opc == 6'h03);
		jr   = (opc == 6'h00 && (fn == 6'h08 || fn == 6'h09));
		call = (opc == 6'h03) || (opc == 6'h00 && fn == 6'h09) ||
			(opc == 6'h01 && (rt == 5'h10 || rt == 5'h11));
		ret  = (opc == 6'h00 && fn == 6'h08 && rs == 5'd31);

		if (br)
			d.cf = ControlFlow_Branch;
		else if (ret)
			d.cf = ControlFlow_Return;
		else if (call)
			d.cf = ControlFlow_Call;
		else if (ji || jr)
			d.cf = ControlFlow_Jump;
		else
			d.cf = ControlFlow_None;
		d.is_cf = br | ji | jr;

		npc = p + 32'd4;
		if (br)
			d.target = npc + {{14{w[15]}}, w[15:0], 2'b00};
		else if (ji)
			d.target = {npc[31:28], w[25:0], 2'b00};

		if (has_imm)
			d.imm = sext ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
		return d;
	endfunction

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] pack_ctrl();
		return {3'b000, out_rs1, out_rs2, out_rd, out_op, out_fu, out_cf, out_is_controlflow};
	endfunction

	task automatic compare_fields(input dec_t e, input word_t w);
		check_eq($sformatf("out_rs1 of %h", w), out_rs1, e.rs1);
		check_eq($sformatf("out_rs2 of %h", w), out_rs2, e.rs2);
		check_eq($sformatf("out_rd of %h", w), out_rd, e.rd);
		check_eq($sformatf("out_op of %h", w), out_op, e.op);
		check_eq($sformatf("out_fu of %h", w), out_fu, e.fu);
		check_eq($sformatf("out_imm of %h", w), out_imm, e.imm);
		check_eq($sformatf("out_cf of %h", w), out_cf, e.cf);
		check_eq($sformatf("out_is_controlflow of %h", w), out_is_controlflow, e.is_cf);
		check_eq($sformatf("out_target of %h", w), out_target, e.target);
	endtask

	// output side sampled on the rising edge, before the register updates
	always @(posedge clk) begin : compare_outputs
		dec_t  exp_dec;
		word_t w;
		word_t p;
		int    acc;

		if (arst_n) begin
			cycle = cycle + 1;
			if (held) begin   // stalled last edge
				check_eq("out_valid while stalled", out_valid, 1'b1);
				check_eq("control fields while stalled", pack_ctrl(), held_ctrl);
				check_eq("out_imm while stalled", out_imm, held_imm);
				check_eq("out_target while stalled", out_target, held_target);
			end
			if (out_valid && out_ready) begin
				n_received++;
				if (q_instr.size() == 0) begin
					n_errors++;
					$display("Output transfer at %0t ns with no instruction in flight", $time);
				end else begin
					w       = q_instr.pop_front();
					p       = q_pc.pop_front();
					acc     = q_cycle.pop_front();
					exp_dec = decode_ref(w, p);
					compare_fields(exp_dec, w);
					if (lat_check)
						check_eq("latency in cycles", cycle - acc, 32'd1);
				end
			end
			held        = out_valid && !out_ready;
			held_ctrl   = pack_ctrl();
			held_imm    = out_imm;
			held_target = out_target;
			if (in_valid && in_ready) begin
				q_instr.push_back(instr);
				q_pc.push_back(pc);
				q_cycle.push_back(cycle);
			end
		end
	end

	always @(negedge clk) begin
		if (rnd_ready)
			out_ready = $random(ready_seed) & 1;
	end

	initial begin
		@(stalled);
		$display("Run stopped at %0t ns: %s", $time, stall_reason);
		$display("TEST FAILED");
		$finish;
	end

	function automatic word_t rand_pc();
		word_t r;
		r = $random(seed);
		return r & 32'hffff_fffc;
	endfunction

	task automatic send_word(input word_t w, input word_t p);
		int n;
		@(negedge clk);
		in_valid = 1'b1;
		instr    = w;
		pc       = p;
		n        = 0;
		@(posedge clk);
		while (!in_ready) begin
			n++;
			in_stalls++;
			if (n == STALL_LIMIT) begin
				stall_reason = "the stage never accepted an instruction";
				-> stalled;
			end
			@(posedge clk);
		end
	endtask

	task automatic drain_stage();
		int n;
		@(negedge clk);
		in_valid = 1'b0;
		n        = 0;
		while (q_instr.size() != 0) begin
			n++;
			if (n == STALL_LIMIT) begin
				stall_reason = "accepted instructions never left the stage";
				-> stalled;
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (arst_n !== 1'b1) begin
			n++;
			if (n == STALL_LIMIT) begin
				stall_reason = "reset was never released";
				-> stalled;
			end
			@(negedge clk);
		end
	endtask

	task automatic end_test(input string name, input int err_mark);
		if (n_errors == err_mark) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d mismatches", name, n_errors - err_mark);
		end
	endtask

	initial begin : run_tests
		int    err_mark;
		int    sent;
		word_t r;

		in_valid   = 1'b0;
		instr      = '0;
		pc         = '0;
		out_ready  = 1'b0;
		lat_check  = 1'b0;
		rnd_ready  = 1'b0;
		held       = 1'b0;
		n_checks   = 0;
		n_errors   = 0;
		n_received = 0;
		tests_ok   = 0;
		tests_bad  = 0;
		cycle      = 0;
		in_stalls  = 0;
		seed       = 32'h9654;
		ready_seed = 32'h9654;
		wait_reset();

		err_mark = n_errors;
		@(negedge clk);
		check_eq("out_valid after reset", out_valid, 1'b0);
		check_eq("in_ready after reset", in_ready, 1'b1);
		check_eq("out_op after reset", out_op, OP_INVALID);
		check_eq("control fields after reset", pack_ctrl(), {18'd0, OP_INVALID, 7'd0});
		check_eq("out_imm after reset", out_imm, 32'd0);
		check_eq("out_target after reset", out_target, 32'd0);
		end_test("reset state", err_mark);

		err_mark  = n_errors;
		out_ready = 1'b1;
		lat_check = 1'b1;
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			send_word({6'h00, r[25:6], i[5:0]}, rand_pc());   // every special funct
			r = $random(seed);
			send_word({6'h1c, r[25:6], i[5:0]}, rand_pc());
			r = $random(seed);
			send_word({i[5:0], r[25:0]}, rand_pc());          // every opcode
			r = $random(seed);
			send_word({6'h10, 5'h10, r[20:6], i[5:0]}, rand_pc());
		end
		for (int i = 0; i < 32; i++) begin
			r = $random(seed);
			send_word({6'h01, r[25:21], i[4:0], r[15:0]}, rand_pc());
			r = $random(seed);
			send_word({6'h10, i[4:0], r[20:0]}, rand_pc());
		end
		drain_stage();
		end_test("opcode and funct tables", err_mark);

		err_mark = n_errors;
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			send_word({6'h04, 5'd3, 5'd4, 16'hfff0}, rand_pc());   // beq backwards
			send_word({6'h01, 5'd7, 5'h11, 16'h0040}, rand_pc());  // bgezal
			send_word({6'h02, r[25:0]}, rand_pc());
			send_word({6'h03, ~r[25:0]}, rand_pc());
			send_word({6'h00, 5'd31, 15'd0, 6'h08}, rand_pc());    // jr ra
			send_word({6'h00, 5'd5, 15'd0, 6'h08}, rand_pc());
			send_word({6'h00, 5'd9, 5'd0, 5'd31, 5'd0, 6'h09}, rand_pc());
		end
		drain_stage();
		end_test("control flow", err_mark);

		err_mark = n_errors;
		send_word({6'h08, 5'd1, 5'd2, 16'h8005}, rand_pc());   // addi, negative
		send_word({6'h0d, 5'd1, 5'd2, 16'hf00f}, rand_pc());   // ori
		send_word({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20}, rand_pc());
		drain_stage();
		end_test("immediates", err_mark);

		err_mark  = n_errors;
		in_stalls = 0;
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			send_word(r, rand_pc());
		end
		drain_stage();
		check_eq("input stalls during burst", in_stalls, 32'd0);
		end_test("latency and throughput", err_mark);

		err_mark   = n_errors;
		lat_check  = 1'b0;
		rnd_ready  = 1'b1;
		n_received = 0;
		sent       = 0;
		for (int i = 0; i < 300; i++) begin
			r = $random(seed);
			send_word(r, rand_pc());
			sent++;
			if ($random(seed) & 1) begin   // idle gap
				@(negedge clk);
				in_valid = 1'b0;
			end
		end
		drain_stage();
		check_eq("instructions received", n_received, sent);
		rnd_ready = 1'b0;
		out_ready = 1'b1;
		end_test("back-pressure", err_mark);

		$display("%0d tests ok, %0d tests with errors, %0d of %0d checks failed",
			tests_ok, tests_bad, n_errors, n_checks);
		if (n_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,
	output logic               in_ready,
	input  cpu_pkg::word_t     instr,
	input  cpu_pkg::word_t     pc,
	output logic               out_valid,
	input  logic               out_ready,
	output cpu_pkg::reg_addr_t out_rs1,
	output cpu_pkg::reg_addr_t out_rs2,
	output cpu_pkg::reg_addr_t out_rd,
	output cpu_pkg::op_t       out_op,
	output cpu_pkg::fu_t       out_fu,
	output cpu_pkg::word_t     out_imm,
	output cpu_pkg::cf_t       out_cf,
	output logic               out_is_controlflow,
	output cpu_pkg::word_t     out_target
);
	import cpu_pkg::*;

	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	op_t       op;
	fu_t       fu;
	logic      use_imm;
	logic      imm_signed;
	logic      is_branch;
	logic      is_jump_i;
	logic      is_jump_r;
	logic      is_call;
	logic      is_return;
	word_t     branch_target;
	word_t     jump_target;

	op_decoder op_dec (
		.instr      (instr),
		.rs1        (rs1),
		.rs2        (rs2),
		.rd         (rd),
		.op         (op),
		.fu         (fu),
		.use_imm    (use_imm),
		.imm_signed (imm_signed)
	);

	branch_decoder br_dec (
		.instr         (instr),
		.pc            (pc),
		.is_branch     (is_branch),
		.is_jump_i     (is_jump_i),
		.is_jump_r     (is_jump_r),
		.is_call       (is_call),
		.is_return     (is_return),
		.branch_target (branch_target),
		.jump_target   (jump_target)
	);

	decode_output dec_out (
		.clk                (clk),
		.arst_n             (arst_n),
		.in_valid           (in_valid),
		.in_ready           (in_ready),
		.instr              (instr),
		.rs1                (rs1),
		.rs2                (rs2),
		.rd                 (rd),
		.op                 (op),
		.fu                 (fu),
		.use_imm            (use_imm),
		.imm_signed         (imm_signed),
		.is_branch          (is_branch),
		.is_jump_i          (is_jump_i),
		.is_jump_r          (is_jump_r),
		.is_call            (is_call),
		.is_return          (is_return),
		.branch_target      (branch_target),
		.jump_target        (jump_target),
		.out_valid          (out_valid),
		.out_ready          (out_ready),
		.out_rs1            (out_rs1),
		.out_rs2            (out_rs2),
		.out_rd             (out_rd),
		.out_op             (out_op),
		.out_fu             (out_fu),
		.out_imm            (out_imm),
		.out_cf             (out_cf),
		.out_is_controlflow (out_is_controlflow),
		.out_target         (out_target)
	);

endmodule

// File: logic/decode_output.sv
`timescale 1ns/1ps

module decode_output (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,
	output logic               in_ready,
	input  cpu_pkg::word_t     instr,
	input  cpu_pkg::reg_addr_t rs1,
	input  cpu_pkg::reg_addr_t rs2,
	input  cpu_pkg::reg_addr_t rd,
	input  cpu_pkg::op_t       op,
	input  cpu_pkg::fu_t       fu,
	input  logic               use_imm,
	input  logic               imm_signed,
	input  logic               is_branch,
	input  logic               is_jump_i,
	input  logic               is_jump_r,
	input  logic               is_call,
	input  logic               is_return,
	input  cpu_pkg::word_t     branch_target,
	input  cpu_pkg::word_t     jump_target,
	output logic               out_valid,
	input  logic               out_ready,
	output cpu_pkg::reg_addr_t out_rs1,
	output cpu_pkg::reg_addr_t out_rs2,
	output cpu_pkg::reg_addr_t out_rd,
	output cpu_pkg::op_t       out_op,
	output cpu_pkg::fu_t       out_fu,
	output cpu_pkg::word_t     out_imm,
	output cpu_pkg::cf_t       out_cf,
	output logic               out_is_controlflow,
	output cpu_pkg::word_t     out_target
);
	import cpu_pkg::*;

	logic  accept;
	cf_t   cf_next;
	word_t imm_next;
	word_t target_next;

	assign in_ready = ~out_valid | out_ready;   // empty or draining this cycle
	assign accept   = in_valid & in_ready;

	always_comb begin
		unique casez ({is_branch, is_return, is_call, is_jump_i | is_jump_r})
			4'b1???: cf_next = ControlFlow_Branch;
			4'b01??: cf_next = ControlFlow_Return;
			4'b001?: cf_next = ControlFlow_Call;
			4'b0001: cf_next = ControlFlow_Jump;
			default: cf_next = ControlFlow_None;
		endcase
	end

	always_comb begin
		if (!use_imm)
			imm_next = '0;
		else if (imm_signed)
			imm_next = {{(WORD_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
		else
			imm_next = {{(WORD_W-IMM_W){1'b0}}, instr[IMM_W-1:0]};
	end

	// register jumps resolve later
	assign target_next = is_branch ? branch_target : (is_jump_i ? jump_target : '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid          <= 1'b0;
			out_rs1            <= '0;
			out_rs2            <= '0;
			out_rd             <= '0;
			out_op             <= OP_INVALID;
			out_fu             <= FU_ALU;
			out_imm            <= '0;
			out_cf             <= ControlFlow_None;
			out_is_controlflow <= 1'b0;
			out_target         <= '0;
		end else begin
			if (in_ready)
				out_valid <= in_valid;
			if (accept) begin
				out_rs1            <= rs1;
				out_rs2            <= rs2;
				out_rd             <= rd;
				out_op             <= op;
				out_fu             <= fu;
				out_imm            <= imm_next;
				out_cf             <= cf_next;
				out_is_controlflow <= is_branch | is_jump_i | is_jump_r;
				out_target         <= target_next;
			end
		end
	end

	a_hold_stalled: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable({out_rs1, out_rs2, out_rd,
			out_op, out_fu, out_imm, out_cf, out_is_controlflow, out_target}))
		else $error("decode_output: payload changed while stalled");

endmodule

// File: logic/branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder (
	input  cpu_pkg::word_t instr,
	input  cpu_pkg::word_t pc,
	output logic           is_branch,
	output logic           is_jump_i,
	output logic           is_jump_r,
	output logic           is_call,
	output logic           is_return,
	output cpu_pkg::word_t branch_target,
	output cpu_pkg::word_t jump_target
);
	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  f_rs;
	logic       regimm_branch;
	word_t      pc_plus4;
	word_t      offset;

	assign opcode = instr[31:26];
	assign f_rs   = instr[25:21];
	assign funct  = instr[5:0];

	// bltz/bgez and their -al forms, rt[3:1] clear
	assign regimm_branch = (opcode == OPC_REGIMM) && (instr[19:17] == 3'b000);

	assign is_branch = (opcode[5:2] == 4'b0001) || regimm_branch;
	assign is_jump_i = (opcode == OPC_J) || (opcode == OPC_JAL);
	assign is_jump_r = (opcode == OPC_SPECIAL) && (funct == FN_JR || funct == FN_JALR);

	assign is_call = (opcode == OPC_JAL) ||
		(is_jump_r && funct == FN_JALR) ||
		(regimm_branch && instr[20]);   // bltzal/bgezal
	assign is_return = (opcode == OPC_SPECIAL) && (funct == FN_JR) && (f_rs == RA_REG);

	assign pc_plus4 = pc + word_t'(4);
	assign offset   = {{(WORD_W-IMM_W-2){instr[IMM_W-1]}}, instr[IMM_W-1:0], 2'b00};

	assign branch_target = pc_plus4 + offset;
	assign jump_target   = {pc_plus4[WORD_W-1 -: 4], instr[JIDX_W-1:0], 2'b00};   // same segment

	a_one_jump_kind: assert final (!(is_jump_i && is_jump_r))
		else $error("branch_decoder: immediate and register jump both set");

endmodule

// File: logic/op_decoder.sv
`timescale 1ns/1ps

module op_decoder (
	input  cpu_pkg::word_t     instr,
	output cpu_pkg::reg_addr_t rs1,
	output cpu_pkg::reg_addr_t rs2,
	output cpu_pkg::reg_addr_t rd,
	output cpu_pkg::op_t       op,
	output cpu_pkg::fu_t       fu,
	output logic               use_imm,
	output logic               imm_signed
);
	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  f_rs;
	reg_addr_t  f_rt;
	reg_addr_t  f_rd;

	assign opcode = instr[31:26];
	assign f_rs   = instr[25:21];
	assign f_rt   = instr[20:16];
	assign f_rd   = instr[15:11];
	assign funct  = instr[5:0];

	always_comb begin
		rs1        = '0;
		rs2        = '0;
		rd         = '0;
		op         = OP_INVALID;
		fu         = FU_INVALID;
		use_imm    = 1'b0;
		imm_signed = 1'b1;

		unique casez (opcode)
			OPC_SPECIAL: begin
				rs1 = f_rs;
				rs2 = f_rt;
				rd  = f_rd;
				fu  = (funct[5:1] == FN_JR[5:1]) ? FU_BRANCH : FU_ALU;   // jr/jalr
				unique case (funct)
					6'b000000: op = OP_SLL;
					6'b000010: op = OP_SRL;
					6'b000011: op = OP_SRA;
					6'b000100: op = OP_SLLV;
					6'b000110: op = OP_SRLV;
					6'b000111: op = OP_SRAV;
					FN_JR:     op = OP_JALR;
					FN_JALR:   op = OP_JALR;
					6'b001010: op = OP_MOVZ;
					6'b001011: op = OP_MOVN;
					6'b001100: op = OP_SYSCALL;
					6'b001101: op = OP_BREAK;
					6'b001111: op = OP_SLL;   // sync acts as a nop
					6'b010000: op = OP_MFHI;
					6'b010001: op = OP_MTHI;
					6'b010010: op = OP_MFLO;
					6'b010011: op = OP_MTLO;
					6'b011000: op = OP_MULT;
					6'b011001: op = OP_MULTU;
					6'b011010: op = OP_DIV;
					6'b011011: op = OP_DIVU;
					6'b100000: op = OP_ADD;
					6'b100001: op = OP_ADDU;
					6'b100010: op = OP_SUB;
					6'b100011: op = OP_SUBU;
					6'b100100: op = OP_AND;
					6'b100101: op = OP_OR;
					6'b100110: op = OP_XOR;
					6'b100111: op = OP_NOR;
					6'b101010: op = OP_SLT;
					6'b101011: op = OP_SLTU;
					6'b110000: op = OP_TGE;
					6'b110001: op = OP_TGEU;
					6'b110010: op = OP_TLT;
					6'b110011: op = OP_TLTU;
					6'b110100: op = OP_TEQ;
					6'b110110: op = OP_TNE;
					default:   op = OP_INVALID;
				endcase
			end
			OPC_SPECIAL2: begin   // no unit assigned here
				rs1 = f_rs;
				rs2 = f_rt;
				rd  = f_rd;
				unique case (funct)
					6'b000000: op = OP_MADD;
					6'b000001: op = OP_MADDU;
					6'b000010: op = OP_MUL;
					6'b000100: op = OP_MSUB;
					6'b000101: op = OP_MSUBU;
					6'b100000: op = OP_CLZ;
					6'b100001: op = OP_CLO;
					default:   op = OP_INVALID;
				endcase
			end
			OPC_REGIMM: begin
				rs1     = f_rs;
				rd      = (instr[20:17] == 4'b1000) ? RA_REG : '0;   // -al forms link
				fu      = (instr[19:17] == 3'b000) ? FU_BRANCH : FU_INVALID;   // traps have no unit
				use_imm = 1'b1;
				unique case (f_rt)
					5'b01000: op = OP_TGE;
					5'b01001: op = OP_TGEU;
					5'b01010: op = OP_TLT;
					5'b01011: op = OP_TLTU;
					5'b01100: op = OP_TEQ;
					5'b01110: op = OP_TNE;
					5'b00000: op = OP_BLTZ;
					5'b00001: op = OP_BGEZ;
					5'b10000: op = OP_BLTZAL;
					5'b10001: op = OP_BGEZAL;
					default:  op = OP_INVALID;
				endcase
			end
			6'b0001??: begin   // beq/bne/blez/bgtz
				rs1 = f_rs;
				rs2 = f_rt;
				fu  = FU_BRANCH;
				unique case (opcode[1:0])
					2'b00: op = OP_BEQ;
					2'b01: op = OP_BNE;
					2'b10: op = OP_BLEZ;
					2'b11: op = OP_BGTZ;
				endcase
			end
			6'b001???: begin
				rs1        = f_rs;
				rd         = f_rt;
				fu         = FU_ALU;
				use_imm    = 1'b1;
				imm_signed = ~opcode[2];   // logic ops zero-extend
				unique case (opcode[2:0])
					3'b000: op = OP_ADD;
					3'b001: op = OP_ADDU;
					3'b010: op = OP_SLT;
					3'b011: op = OP_SLTU;
					3'b100: op = OP_AND;
					3'b101: op = OP_OR;
					3'b110: op = OP_XOR;
					3'b111: op = OP_LUI;
				endcase
			end
			6'b100???: begin
				rs1 = f_rs;
				rs2 = (opcode[1:0] == 2'b10) ? f_rt : '0;   // lwl/lwr merge with rt
				rd  = f_rt;
				fu  = FU_LOAD;
				unique case (opcode[2:0])
					3'b000: op = OP_LB;
					3'b001: op = OP_LH;
					3'b010: op = OP_LWL;
					3'b011: op = OP_LW;
					3'b100: op = OP_LBU;
					3'b101: op = OP_LHU;
					3'b110: op = OP_LWR;
					3'b111: op = OP_INVALID;
				endcase
			end
			6'b101???: begin
				rs1 = f_rs;
				rs2 = f_rt;
				fu  = FU_STORE;
				unique case (opcode[2:0])
					3'b000:  op = OP_SB;
					3'b001:  op = OP_SH;
					3'b010:  op = OP_SWL;
					3'b011:  op = OP_SW;
					3'b110:  op = OP_SWR;
					3'b111:  op = OP_CACHE;
					default: op = OP_INVALID;
				endcase
			end
			OPC_LL: begin
				rs1 = f_rs;
				rd  = f_rt;
				fu  = FU_LOAD;
				op  = OP_LL;
			end
			OPC_SC: begin
				rs1 = f_rs;
				rs2 = f_rt;
				rd  = f_rt;   // success flag
				fu  = FU_STORE;
				op  = OP_SC;
			end
			6'b00001?: begin   // j and jal
				rd = opcode[0] ? RA_REG : '0;
				fu = FU_BRANCH;
				op = OP_JAL;
			end
			OPC_COP0: begin
				fu = FU_CP0;
				unique case (f_rs)
					5'b00000: begin
						op = OP_MFC0;
						rd = f_rt;
					end
					5'b00100: begin
						op  = OP_MTC0;
						rs1 = f_rt;
					end
					5'b10000: begin
						unique case (funct)
							6'b000001: op = OP_TLBR;
							6'b000010: op = OP_TLBWI;
							6'b000110: op = OP_TLBWR;
							6'b001000: op = OP_TLBP;
							6'b011000: op = OP_ERET;
							default:   op = OP_INVALID;
						endcase
					end
					default: op = OP_INVALID;
				endcase
			end
			default: op = OP_INVALID;
		endcase
	end

	a_op_has_unit: assert final (op == OP_INVALID || fu != FU_INVALID ||
		opcode == OPC_SPECIAL2 || opcode == OPC_REGIMM)
		else $error("op_decoder: %s decoded without a unit", op.name());

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W      = 16;
	localparam int JIDX_W     = 26;   // j/jal index field

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	localparam reg_addr_t RA_REG = 5'd31;   // link register

	// major opcodes that are matched as a whole
	typedef enum logic [5:0] {
		OPC_SPECIAL  = 6'b000000,
		OPC_REGIMM   = 6'b000001,
		OPC_J        = 6'b000010,
		OPC_JAL      = 6'b000011,
		OPC_COP0     = 6'b010000,
		OPC_SPECIAL2 = 6'b011100,
		OPC_LL       = 6'b110000,
		OPC_SC       = 6'b111000
	} opcode_t;

	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;

	typedef enum logic [6:0] {
		OP_INVALID = 7'd0,
		// shifts
		OP_SLL, OP_SRL, OP_SRA,
		OP_SLLV, OP_SRLV, OP_SRAV,
		// moves
		OP_MOVN, OP_MOVZ,
		OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
		// multiply and divide
		OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
		OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
		OP_MUL, OP_CLZ, OP_CLO,
		// arithmetic and logic
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_LUI,
		// compare
		OP_SLT, OP_SLTU,
		// traps and system
		OP_TGE, OP_TGEU, OP_TLT, OP_TLTU,
		OP_TEQ, OP_TNE,
		OP_SYSCALL, OP_BREAK,
		// branches and jumps
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
		OP_JAL, OP_JALR,
		// memory
		OP_LB, OP_LH, OP_LWL, OP_LW,
		OP_LBU, OP_LHU, OP_LWR,
		OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR,
		OP_LL, OP_SC, OP_CACHE,
		// coprocessor 0
		OP_MFC0, OP_MTC0,
		OP_TLBR, OP_TLBWI, OP_TLBWR, OP_TLBP,
		OP_ERET
	} op_t;

	typedef enum logic [2:0] {
		FU_ALU,
		FU_BRANCH,
		FU_LOAD,
		FU_STORE,
		FU_CP0,
		FU_INVALID
	} fu_t;

	typedef enum logic [2:0] {
		ControlFlow_None,
		ControlFlow_Branch,
		ControlFlow_Jump,
		ControlFlow_Call,
		ControlFlow_Return
	} cf_t;

endpackage
